//--- rtl/cache_pkg.sv
//------------------------------------------------
// shared widths, type codes and address fields for
// the blocking cache; refer to them as cache_pkg::name
//------------------------------------------------

package cache_pkg;

  //------------------------------------------------
  // widths
  //------------------------------------------------

  // processor and memory byte address
  localparam int addr_nbits   = 32;
  // processor word
  localparam int word_nbits   = 32;
  // memory beat, same as one cache line
  localparam int line_nbits   = 128;
  // request tag, echoed back untouched
  localparam int opaque_nbits = 8;

  //------------------------------------------------
  // address fields
  //------------------------------------------------

  // byte offset inside a 16-byte line
  localparam int offset_nbits   = 4;
  // word select sits above the byte-in-word bits
  localparam int word_sel_lsb   = 2;
  localparam int word_sel_nbits = offset_nbits - word_sel_lsb;

  //------------------------------------------------
  // type codes
  //------------------------------------------------

  // processor request and response type, same codes both ways
  typedef enum logic [1:0] {
    req_read       = 2'd0,
    req_write      = 2'd1,
    req_write_init = 2'd2
  } req_type_t;

  // memory side request type
  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_type_t;

  // controller FSM states
  typedef enum logic [2:0] {
    st_idle, st_tag_check, st_evict_req, st_evict_wait,
    st_refill_req, st_refill_wait, st_update, st_respond
  } state_t;

endpackage

//--- rtl/cache_ctrl.sv
//------------------------------------------------
// control FSM of the blocking cache: tag check,
// write-back, refill and response, one request at a time
//------------------------------------------------

`timescale 1ns/1ps

module cache_ctrl
#(
  parameter int p_num_lines = 16
)
(
  input  logic clk,
  input  logic rst,

  // processor handshakes
  input  logic cachereq_val,
  output logic cachereq_rdy,
  output logic cacheresp_val,
  input  logic cacheresp_rdy,

  // memory handshakes
  output logic memreq_val,
  input  logic memreq_rdy,
  input  logic memresp_val,
  output logic memresp_rdy,

  // status from the datapath
  input  logic hit,
  input  logic victim_dirty,

  // strobes into the datapath
  output logic memreq_is_write,
  output logic req_load,
  output logic line_write,
  output logic word_write,
  output logic refill_select
);

  // geometry, only checked here
  localparam int index_nbits = $clog2(p_num_lines);
  localparam int tag_nbits   =
    cache_pkg::addr_nbits - cache_pkg::offset_nbits - index_nbits;

  cache_pkg::state_t state;
  cache_pkg::state_t state_next;

  //------------------------------------------------
  // state register
  //------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= cache_pkg::st_idle;
    else
      state <= state_next;
  end

  //------------------------------------------------
  // next state
  //------------------------------------------------

  always_comb
  begin
    state_next = state;
    unique case (state)
      // wait for a request
      cache_pkg::st_idle:
        if (cachereq_val)
          state_next = cache_pkg::st_tag_check;
      // hit goes straight to the response
      cache_pkg::st_tag_check:
        if (hit)
          state_next = cache_pkg::st_respond;
        else if (victim_dirty)
          state_next = cache_pkg::st_evict_req;
        else
          state_next = cache_pkg::st_refill_req;
      // dirty victim out first
      cache_pkg::st_evict_req:
        if (memreq_rdy)
          state_next = cache_pkg::st_evict_wait;
      // write ack, data ignored
      cache_pkg::st_evict_wait:
        if (memresp_val)
          state_next = cache_pkg::st_refill_req;
      cache_pkg::st_refill_req:
        if (memreq_rdy)
          state_next = cache_pkg::st_refill_wait;
      // line lands in the arrays on this edge
      cache_pkg::st_refill_wait:
        if (memresp_val)
          state_next = cache_pkg::st_update;
      // store merge on the fresh line
      cache_pkg::st_update:
        state_next = cache_pkg::st_respond;
      // hold until the processor takes it
      cache_pkg::st_respond:
        if (cacheresp_rdy)
          state_next = cache_pkg::st_idle;
    endcase
  end

  //------------------------------------------------
  // outputs, decoded from state
  //------------------------------------------------

  assign cachereq_rdy  = (state == cache_pkg::st_idle);
  assign cacheresp_val = (state == cache_pkg::st_respond);

  // request goes out in the two req states only
  assign memreq_val      = (state == cache_pkg::st_evict_req)
                        || (state == cache_pkg::st_refill_req);
  assign memreq_is_write = (state == cache_pkg::st_evict_req);
  assign refill_select   = (state == cache_pkg::st_refill_req);

  assign memresp_rdy = (state == cache_pkg::st_evict_wait)
                    || (state == cache_pkg::st_refill_wait);

  // capture the request on the accepting edge
  assign req_load   = cachereq_rdy && cachereq_val;
  assign line_write = (state == cache_pkg::st_refill_wait) && memresp_val;

  // datapath drops the merge for reads
  assign word_write = ((state == cache_pkg::st_tag_check) && hit)
                   || (state == cache_pkg::st_update);

  //------------------------------------------------
  // checks
  //------------------------------------------------

  // power-of-two line count, tag left over
  initial
  begin
    assert (((1 << index_nbits) == p_num_lines) && (tag_nbits > 0))
      else $fatal(1, "cache_ctrl: bad p_num_lines %0d", p_num_lines);
  end

  // never talk to both sides in one cycle
  a_resp_mem_excl: assert property (@(posedge clk) disable iff (rst)
    !(cacheresp_val && memreq_val))
    else $error("cache_ctrl: cacheresp_val and memreq_val both high");

  // memory only answers what we asked for
  a_memresp_in_wait: assert property (@(posedge clk) disable iff (rst)
    memresp_val |-> (state == cache_pkg::st_evict_wait)
                 || (state == cache_pkg::st_refill_wait))
    else $error("cache_ctrl: memresp_val outside a wait state");

endmodule

//--- rtl/cache_dpath.sv
//------------------------------------------------
// cache datapath: request registers, tag/valid/dirty
// and data arrays, word merge and memory request build
//------------------------------------------------

`timescale 1ns/1ps

module cache_dpath
#(
  parameter int p_num_lines = 16
)
(
  input  logic                                  clk,
  input  logic                                  rst,

  // processor request payload
  input  cache_pkg::req_type_t                  cachereq_type,
  input  logic [cache_pkg::opaque_nbits-1:0]    cachereq_opaque,
  input  logic [cache_pkg::addr_nbits-1:0]      cachereq_addr,
  input  logic [cache_pkg::word_nbits-1:0]      cachereq_data,

  // strobes from the FSM
  input  logic                                  req_load,
  input  logic                                  line_write,
  input  logic                                  word_write,
  input  logic                                  refill_select,
  input  logic                                  memreq_is_write,

  input  logic [cache_pkg::line_nbits-1:0]      memresp_data,

  // status back to the FSM
  output logic                                  hit,
  output logic                                  victim_dirty,

  // processor response payload
  output cache_pkg::req_type_t                  cacheresp_type,
  output logic [cache_pkg::opaque_nbits-1:0]    cacheresp_opaque,
  output logic [cache_pkg::word_nbits-1:0]      cacheresp_data,

  // memory request payload
  output cache_pkg::mem_type_t                  memreq_type,
  output logic [cache_pkg::addr_nbits-1:0]      memreq_addr,
  output logic [cache_pkg::line_nbits-1:0]      memreq_data
);

  localparam int index_nbits = $clog2(p_num_lines);
  localparam int tag_nbits   =
    cache_pkg::addr_nbits - cache_pkg::offset_nbits - index_nbits;

  // accepted request, address already split
  cache_pkg::req_type_t                     req_type;
  logic [cache_pkg::opaque_nbits-1:0]       req_opaque;
  logic [cache_pkg::word_nbits-1:0]         req_data;
  logic [tag_nbits-1:0]                     req_tag;
  logic [index_nbits-1:0]                   req_idx;
  logic [cache_pkg::word_sel_nbits-1:0]     req_word;

  // arrays
  logic [tag_nbits-1:0]                     tag_array  [p_num_lines];
  logic [cache_pkg::line_nbits-1:0]         data_array [p_num_lines];
  logic [p_num_lines-1:0]                   valid;
  logic [p_num_lines-1:0]                   dirty;

  logic [cache_pkg::line_nbits-1:0]         cur_line;
  logic                                     req_is_store;
  // refill asked for and not yet written
  logic                                     refill_pending;

  assign req_is_store = (req_type != cache_pkg::req_read);
  assign cur_line     = data_array[req_idx];

  //------------------------------------------------
  // request register and arrays
  //------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (req_load)
    begin
      req_type   <= cachereq_type;
      req_opaque <= cachereq_opaque;
      req_data   <= cachereq_data;
      req_tag    <= cachereq_addr[cache_pkg::addr_nbits-1 -: tag_nbits];
      req_idx    <= cachereq_addr[cache_pkg::offset_nbits +: index_nbits];
      req_word   <= cachereq_addr[cache_pkg::word_sel_lsb +: cache_pkg::word_sel_nbits];
    end
    // whole line from memory
    if (line_write)
    begin
      data_array[req_idx] <= memresp_data;
      tag_array[req_idx]  <= req_tag;
    end
    // write and write_init merge one word
    if (word_write && req_is_store)
      data_array[req_idx][req_word*cache_pkg::word_nbits +: cache_pkg::word_nbits] <= req_data;
  end

  //------------------------------------------------
  // valid and dirty bits
  //------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid          <= '0;
      dirty          <= '0;
      refill_pending <= 1'b0;
    end
    else
    begin
      if (line_write)
      begin
        valid[req_idx] <= 1'b1;
        dirty[req_idx] <= 1'b0;
      end
      if (word_write && req_is_store)
        dirty[req_idx] <= 1'b1;
      if (refill_select)
        refill_pending <= 1'b1;
      else if (line_write)
        refill_pending <= 1'b0;
    end
  end

  //------------------------------------------------
  // status and outputs
  //------------------------------------------------

  assign hit          = valid[req_idx] && (tag_array[req_idx] == req_tag);
  assign victim_dirty = valid[req_idx] && dirty[req_idx];

  // response echoes the request fields
  assign cacheresp_type   = req_type;
  assign cacheresp_opaque = req_opaque;
  assign cacheresp_data   =
    cur_line[req_word*cache_pkg::word_nbits +: cache_pkg::word_nbits];

  // victim address from the stored tag, refill from the request
  assign memreq_addr = refill_select
    ? {req_tag, req_idx, {cache_pkg::offset_nbits{1'b0}}}
    : {tag_array[req_idx], req_idx, {cache_pkg::offset_nbits{1'b0}}};
  assign memreq_type = memreq_is_write ? cache_pkg::mem_write : cache_pkg::mem_read;
  assign memreq_data = memreq_is_write ? cur_line : '0;

  // line write only after a refill read went out
  a_line_after_refill: assert property (@(posedge clk) disable iff (rst)
    line_write |-> refill_pending)
    else $error("cache_dpath: line write without a refill request");

endmodule

//--- rtl/blocking_cache.sv
//------------------------------------------------
// blocking direct-mapped write-back data cache;
// word requests in, 128-bit line memory out
//------------------------------------------------

`timescale 1ns/1ps

module blocking_cache
#(
  parameter int p_num_lines = 16
)
(
  input  logic                                  clk,
  input  logic                                  rst,

  // processor request
  input  logic                                  cachereq_val,
  output logic                                  cachereq_rdy,
  input  cache_pkg::req_type_t                  cachereq_type,
  input  logic [cache_pkg::opaque_nbits-1:0]    cachereq_opaque,
  input  logic [cache_pkg::addr_nbits-1:0]      cachereq_addr,
  input  logic [cache_pkg::word_nbits-1:0]      cachereq_data,

  // processor response
  output logic                                  cacheresp_val,
  input  logic                                  cacheresp_rdy,
  output cache_pkg::req_type_t                  cacheresp_type,
  output logic [cache_pkg::opaque_nbits-1:0]    cacheresp_opaque,
  output logic [cache_pkg::word_nbits-1:0]      cacheresp_data,

  // memory request, line aligned
  output logic                                  memreq_val,
  input  logic                                  memreq_rdy,
  output cache_pkg::mem_type_t                  memreq_type,
  output logic [cache_pkg::addr_nbits-1:0]      memreq_addr,
  output logic [cache_pkg::line_nbits-1:0]      memreq_data,

  // memory response
  input  logic                                  memresp_val,
  output logic                                  memresp_rdy,
  input  logic [cache_pkg::line_nbits-1:0]      memresp_data
);

  // FSM to datapath
  logic req_load;
  logic line_write;
  logic word_write;
  logic refill_select;
  logic memreq_is_write;

  // datapath to FSM
  logic hit;
  logic victim_dirty;

  cache_ctrl #(.p_num_lines(p_num_lines)) ctrl
  (
    .clk             (clk),
    .rst             (rst),
    .cachereq_val    (cachereq_val),
    .cachereq_rdy    (cachereq_rdy),
    .cacheresp_val   (cacheresp_val),
    .cacheresp_rdy   (cacheresp_rdy),
    .memreq_val      (memreq_val),
    .memreq_rdy      (memreq_rdy),
    .memresp_val     (memresp_val),
    .memresp_rdy     (memresp_rdy),
    .hit             (hit),
    .victim_dirty    (victim_dirty),
    .memreq_is_write (memreq_is_write),
    .req_load        (req_load),
    .line_write      (line_write),
    .word_write      (word_write),
    .refill_select   (refill_select)
  );

  cache_dpath #(.p_num_lines(p_num_lines)) dpath
  (
    .clk              (clk),
    .rst              (rst),
    .cachereq_type    (cachereq_type),
    .cachereq_opaque  (cachereq_opaque),
    .cachereq_addr    (cachereq_addr),
    .cachereq_data    (cachereq_data),
    .req_load         (req_load),
    .line_write       (line_write),
    .word_write       (word_write),
    .refill_select    (refill_select),
    .memreq_is_write  (memreq_is_write),
    .memresp_data     (memresp_data),
    .hit              (hit),
    .victim_dirty     (victim_dirty),
    .cacheresp_type   (cacheresp_type),
    .cacheresp_opaque (cacheresp_opaque),
    .cacheresp_data   (cacheresp_data),
    .memreq_type      (memreq_type),
    .memreq_addr      (memreq_addr),
    .memreq_data      (memreq_data)
  );

endmodule

//--- tests/tb_line_mem.sv
//------------------------------------------------
// line memory model for the cache testbench; stall
// inputs come from the testbench LFSR, load_line is a backdoor
//------------------------------------------------

`timescale 1ns/1ps

module tb_line_mem
(
  input  logic                               clk,
  input  logic                               rst,

  // memory request from the cache
  input  logic                               memreq_val,
  output logic                               memreq_rdy,
  input  cache_pkg::mem_type_t               memreq_type,
  input  logic [cache_pkg::addr_nbits-1:0]   memreq_addr,
  input  logic [cache_pkg::line_nbits-1:0]   memreq_data,

  // memory response to the cache
  output logic                               memresp_val,
  input  logic                               memresp_rdy,
  output logic [cache_pkg::line_nbits-1:0]   memresp_data,

  // random delay control
  input  logic                               req_stall,
  input  logic                               resp_stall
);

  // 64 lines, indexed by address bits 9:4
  logic [cache_pkg::line_nbits-1:0] lines [64];
  // one request taken, response not yet transferred
  logic                             pending;

  assign memreq_rdy = !pending && !req_stall;

  always @(posedge clk)
  begin
    if (rst)
    begin
      pending     <= 1'b0;
      memresp_val <= 1'b0;
    end
    else
    begin
      if (memreq_val && memreq_rdy)
      begin
        pending <= 1'b1;
        if (memreq_type == cache_pkg::mem_write)
        begin
          lines[memreq_addr[9:4]] <= memreq_data;
          // write ack carries no data
          memresp_data <= '0;
        end
        else
          memresp_data <= lines[memreq_addr[9:4]];
      end
      // response rises after a random wait, then holds
      if (pending && !memresp_val && !resp_stall)
        memresp_val <= 1'b1;
      if (memresp_val && memresp_rdy)
      begin
        memresp_val <= 1'b0;
        pending     <= 1'b0;
      end
    end
  end

  // backdoor preload
  task load_line(input logic [5:0] idx, input logic [cache_pkg::line_nbits-1:0] data);
    lines[idx] = data;
  endtask

endmodule

//--- tests/cache_tb.sv
//------------------------------------------------
// testbench for the blocking cache: random requests on
// conflicting lines, checked against a reference model
//------------------------------------------------

`timescale 1ns/1ps

module cache_tb;

  localparam int num_reqs     = 400;
  localparam int wait_timeout = 200;

  logic         clk;
  logic         rst;
  logic         cachereq_val;
  logic         cachereq_rdy;
  cache_pkg::req_type_t cachereq_type;
  logic [7:0]   cachereq_opaque;
  logic [31:0]  cachereq_addr;
  logic [31:0]  cachereq_data;
  logic         cacheresp_val;
  logic         cacheresp_rdy;
  cache_pkg::req_type_t cacheresp_type;
  logic [7:0]   cacheresp_opaque;
  logic [31:0]  cacheresp_data;
  logic         memreq_val;
  logic         memreq_rdy;
  cache_pkg::mem_type_t memreq_type;
  logic [31:0]  memreq_addr;
  logic [127:0] memreq_data;
  logic         memresp_val;
  logic         memresp_rdy;
  logic [127:0] memresp_data;
  logic         req_stall;
  logic         resp_stall;

  // galois LFSR state
  logic [31:0]  lfsr = 32'hd18b9973;
  int           errors;
  logic         timed_out;

  // reference model: flat words plus direct-mapped tag state
  logic [31:0]  ref_mem [256];
  logic [23:0]  m_tag   [16];
  logic [15:0]  m_valid;
  logic [15:0]  m_dirty;

  // memory transfers seen: {type, addr, data}
  logic [160:0] mem_log [$];
  logic         mreq_hold;
  logic [160:0] mreq_prev;
  logic         resp_hold;
  logic [41:0]  resp_prev;

  blocking_cache #(.p_num_lines(16)) DUT (.*);

  tb_line_mem mem (.*);

  always #5 clk = ~clk;

  //------------------------------------------------
  // helpers
  //------------------------------------------------

  // one LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // preload pattern, every address bit matters
  function automatic logic [31:0] preload_word(input logic [31:0] a);
    return (a * 32'h9e3779b1) ^ 32'h5a5a0f0f;
  endfunction

  // line as the model sees it, word 0 in the low bits
  function automatic logic [127:0] model_line(input logic [1:0] tg, input logic [3:0] idx);
    return {ref_mem[{tg, idx, 2'd3}], ref_mem[{tg, idx, 2'd2}],
            ref_mem[{tg, idx, 2'd1}], ref_mem[{tg, idx, 2'd0}]};
  endfunction

  //------------------------------------------------
  // random stalls and payload monitors
  //------------------------------------------------

  always @(posedge clk)
  begin
    #1;
    cacheresp_rdy = (rand_bits(2) != 32'd0);
    req_stall     = (rand_bits(2) == 32'd0);
    resp_stall    = (rand_bits(2) == 32'd0);
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      mreq_hold = 1'b0;
      resp_hold = 1'b0;
    end
    else
    begin
      // stalled payloads must not move
      if (mreq_hold)
        assert (memreq_val && ({memreq_type, memreq_addr, memreq_data} == mreq_prev))
        else
        begin
          errors++;
          $display("Mismatch at %0t: memory request changed while stalled", $time);
        end
      if (resp_hold)
        assert (cacheresp_val
                && ({cacheresp_type, cacheresp_opaque, cacheresp_data} == resp_prev))
        else
        begin
          errors++;
          $display("Mismatch at %0t: response changed while stalled", $time);
        end
      if (memreq_val && memreq_rdy)
        mem_log.push_back({memreq_type, memreq_addr, memreq_data});
      mreq_hold = memreq_val && !memreq_rdy;
      mreq_prev = {memreq_type, memreq_addr, memreq_data};
      resp_hold = cacheresp_val && !cacheresp_rdy;
      resp_prev = {cacheresp_type, cacheresp_opaque, cacheresp_data};
    end
  end

  //------------------------------------------------
  // one request, start to response
  //------------------------------------------------

  task automatic run_request();
    logic [31:0]  r;
    logic [1:0]   tg;
    logic [3:0]   idx;
    logic [1:0]   w;
    logic         resident;
    logic [160:0] exp_ops [2];
    int           n_exp;
    int           cyc;
    int           first_val;
    logic         done;
    r = rand_bits(2);
    if (r[1:0] == 2'd1)
      cachereq_type = cache_pkg::req_write;
    else if (r[1:0] == 2'd2)
      cachereq_type = cache_pkg::req_write_init;
    else
      cachereq_type = cache_pkg::req_read;
    r   = rand_bits(6);
    tg  = r[5:4];
    // index 0, 5, 10 or 15; tags collide on each
    idx = {r[3:2], r[3:2]};
    w   = r[1:0];
    cachereq_addr   = {22'd0, tg, idx, w, 2'b00};
    cachereq_opaque = 8'(rand_bits(8));
    cachereq_data   = rand_bits(32);
    resident = m_valid[idx] && (m_tag[idx] == {22'd0, tg});
    // expected memory traffic
    n_exp = 0;
    if (!resident)
    begin
      if (m_valid[idx] && m_dirty[idx])
      begin
        exp_ops[0] = {1'b1, 22'd0, m_tag[idx][1:0], idx, 4'd0,
                      model_line(m_tag[idx][1:0], idx)};
        n_exp = 1;
      end
      exp_ops[n_exp] = {1'b0, 22'd0, tg, idx, 4'd0, 128'd0};
      n_exp++;
    end
    mem_log.delete();
    cachereq_val = 1'b1;
    // acceptance
    cyc  = 0;
    done = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      cyc++;
      if (cachereq_rdy)
        done = 1'b1;
      else if (cyc > wait_timeout)
      begin
        errors++;
        timed_out = 1'b1;
        $display("timeout: cache never accepted the request at %0t", $time);
        return;
      end
    end
    #1 cachereq_val = 1'b0;
    // response transfer
    cyc       = 0;
    first_val = 0;
    done      = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      cyc++;
      assert (!cachereq_rdy)
      else
      begin
        errors++;
        $display("Mismatch at %0t: second request could be accepted", $time);
      end
      if (cacheresp_val && (first_val == 0))
        first_val = cyc;
      if (cacheresp_val && cacheresp_rdy)
        done = 1'b1;
      else if (cyc > wait_timeout)
      begin
        errors++;
        timed_out = 1'b1;
        $display("timeout: no response for address %h at %0t", cachereq_addr, $time);
        return;
      end
    end
    // echoed fields and read data
    assert ((cacheresp_opaque == cachereq_opaque) && (cacheresp_type == cachereq_type))
    else
    begin
      errors++;
      $display("Mismatch at %0t: opaque/type %h/%0d, expected %h/%0d", $time,
               cacheresp_opaque, cacheresp_type, cachereq_opaque, cachereq_type);
    end
    if (cachereq_type == cache_pkg::req_read)
      assert (cacheresp_data == ref_mem[{tg, idx, w}])
      else
      begin
        errors++;
        $display("Mismatch at %0t: read %h got %h, expected %h", $time,
                 cachereq_addr, cacheresp_data, ref_mem[{tg, idx, w}]);
      end
    if (resident)
      assert (first_val == 2)
      else
      begin
        errors++;
        $display("Mismatch at %0t: hit response after %0d edges", $time, first_val);
      end
    // memory traffic against the model
    assert (mem_log.size() == n_exp)
    else
    begin
      errors++;
      $display("Mismatch at %0t: %0d memory requests, expected %0d", $time,
               mem_log.size(), n_exp);
    end
    for (int i = 0; i < n_exp && i < mem_log.size(); i++)
      assert ((mem_log[i][160:128] == exp_ops[i][160:128])
              && (!exp_ops[i][160] || (mem_log[i][127:0] == exp_ops[i][127:0])))
      else
      begin
        errors++;
        $display("Mismatch at %0t: memory request %0d is %h, expected %h", $time,
                 i, mem_log[i], exp_ops[i]);
      end
    // model update
    if (!resident)
    begin
      m_valid[idx] = 1'b1;
      m_dirty[idx] = 1'b0;
      m_tag[idx]   = {22'd0, tg};
    end
    if (cachereq_type != cache_pkg::req_read)
    begin
      ref_mem[{tg, idx, w}] = cachereq_data;
      m_dirty[idx]          = 1'b1;
    end
  endtask

  //------------------------------------------------
  // main sequence
  //------------------------------------------------

  initial
  begin
    logic [127:0] line;
    clk             = 1'b0;
    rst             = 1'b1;
    cachereq_val    = 1'b0;
    cachereq_type   = cache_pkg::req_read;
    cachereq_opaque = '0;
    cachereq_addr   = '0;
    cachereq_data   = '0;
    cacheresp_rdy   = 1'b0;
    req_stall       = 1'b0;
    resp_stall      = 1'b0;
    errors          = 0;
    timed_out       = 1'b0;
    m_valid         = '0;
    m_dirty         = '0;
    // preload memory and mirror it in the model
    for (int i = 0; i < 64; i++)
    begin
      for (int k = 0; k < 4; k++)
      begin
        line[k*32 +: 32] = preload_word({22'd0, i[5:0], k[1:0], 2'b00});
        ref_mem[{i[5:0], k[1:0]}] = line[k*32 +: 32];
      end
      mem.load_line(i[5:0], line);
    end
    // reset for 3 cycles, outputs quiet once it took hold
    @(posedge clk);
    repeat (2)
    begin
      @(posedge clk);
      assert (!cacheresp_val && !memreq_val && !memresp_rdy)
      else
      begin
        errors++;
        $display("Mismatch at %0t: valid or ready output high during reset", $time);
      end
    end
    #1 rst = 1'b0;
    @(posedge clk);
    assert (cachereq_rdy && !cacheresp_val && !memreq_val && !memresp_rdy)
    else
    begin
      errors++;
      $display("Mismatch at %0t: wrong outputs right after reset", $time);
    end
    #1;
    for (int n = 0; n < num_reqs && !timed_out; n++)
    begin
      run_request();
      #1;
    end
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- filelist.f
rtl/cache_pkg.sv
rtl/cache_ctrl.sv
rtl/cache_dpath.sv
rtl/blocking_cache.sv
tests/tb_line_mem.sv
tests/cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module cache_tb -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
if ! grep -q "Test passed" sim.log; then
  exit 1
fi
exit 0
